//--- Makefile
# Verilator build and run of the edge data fetch testbench

VERILATOR ?= verilator
TOP       ?= edge_fetch_tb
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_TEXT ?= All tests passed!

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	@output="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$output"; \
	echo "$$output" | grep -qF "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)

//--- source/edge_data_fetch.sv
/* Top level of the edge data fetch unit. Connects the read requester,
   one capture per response lane and the word extractor. */

module edge_data_fetch (
	input  logic                      clock,
	input  logic                      rstn,
	input  logic [63:0]               base_address,
	input  logic [31:0]               afu_config,
	input  edge_fetch_pkg::edge_job_t  edge_job,
	input  logic                      edge_job_valid,
	output logic                      edge_job_ready,
	output edge_fetch_pkg::read_cmd_t  read_cmd,
	output logic                      read_cmd_valid,
	input  logic                      read_cmd_ready,
	input  edge_fetch_pkg::half_beat_t lane0_beat,
	input  logic                      lane0_beat_valid,
	input  edge_fetch_pkg::half_beat_t lane1_beat,
	input  logic                      lane1_beat_valid,
	output edge_fetch_pkg::edge_data_t edge_data,
	output logic                      edge_data_valid,
	input  logic                      edge_data_ready
);

	import edge_fetch_pkg::*;

	half_beat_t lane0_half;
	half_beat_t lane1_half;
	logic       lane0_half_valid;
	logic       lane1_half_valid;
	logic       take;
	logic       delivered;

	edge_read_requester requester_i (
		.clock         (clock),
		.rstn          (rstn),
		.base_address  (base_address),
		.afu_config    (afu_config),
		.edge_job      (edge_job),
		.edge_job_valid(edge_job_valid),
		.edge_job_ready(edge_job_ready),
		.read_cmd      (read_cmd),
		.read_cmd_valid(read_cmd_valid),
		.read_cmd_ready(read_cmd_ready),
		.delivered     (delivered)
	);

	// bytes 0 to 31 of the line
	half_line_capture lane0_i (
		.clock     (clock),
		.rstn      (rstn),
		.beat      (lane0_beat),
		.beat_valid(lane0_beat_valid),
		.half      (lane0_half),
		.half_valid(lane0_half_valid),
		.take      (take)
	);

	// bytes 32 to 63
	half_line_capture lane1_i (
		.clock     (clock),
		.rstn      (rstn),
		.beat      (lane1_beat),
		.beat_valid(lane1_beat_valid),
		.half      (lane1_half),
		.half_valid(lane1_half_valid),
		.take      (take)
	);

	line_word_extractor extractor_i (
		.clock          (clock),
		.rstn           (rstn),
		.half_lo        (lane0_half),
		.half_hi        (lane1_half),
		.lo_valid       (lane0_half_valid),
		.hi_valid       (lane1_half_valid),
		.take           (take),
		.edge_data      (edge_data),
		.edge_data_valid(edge_data_valid),
		.edge_data_ready(edge_data_ready),
		.delivered      (delivered)
	);

endmodule

//--- source/edge_fetch_pkg.sv
/* Shared sizes, command codes and bus types of the edge data fetch unit.
   Every module of the unit imports this package. */

package edge_fetch_pkg;

	////////////////////////////////////////
	// sizes
	////////////////////////////////////////
	localparam int LINE_BITS        = 512;
	localparam int HALF_BITS        = 256;
	localparam int WORD_BITS        = 32;
	localparam int WORDS_PER_LINE   = 16;
	localparam int HALF_WORDS       = 8;
	localparam int MAX_OUTSTANDING  = 8;
	localparam int JOB_FIFO_DEPTH   = 4;
	localparam int SHARED_READ_BIT  = 31;
	localparam int OUTSTANDING_BITS = $clog2(MAX_OUTSTANDING + 1);

	// shared read or non-allocating read
	typedef enum logic [12:0] {
		READ_CL_S  = 13'h0A50,
		READ_CL_NA = 13'h0A00
	} cmd_code_e;

	////////////////////////////////////////
	// bus types
	////////////////////////////////////////
	typedef struct packed {
		logic [31:0] src;
		logic [31:0] dest;
	} edge_job_t;

	// offset is the word index inside the line
	typedef struct packed {
		logic [31:0] dest;
		logic [3:0]  offset;
	} read_tag_t;

	typedef struct packed {
		cmd_code_e   code;
		logic [63:0] address;
		logic [3:0]  size;
		read_tag_t   tag;
	} read_cmd_t;

	typedef struct packed {
		logic [HALF_BITS-1:0] data;
		read_tag_t            tag;
	} half_beat_t;

	typedef struct packed {
		logic [31:0] dest;
		logic [31:0] data;
	} edge_data_t;

	// filled by halves, read by words
	typedef union packed {
		logic [1:0][HALF_BITS-1:0]                 halves;
		logic [WORDS_PER_LINE-1:0][WORD_BITS-1:0] words;
	} cache_line_u;

endpackage

//--- source/edge_read_requester.sv
/* Buffers edge jobs and turns each into a one-word read command.
   A credit counter keeps reads in flight within the output queue depth. */

module edge_read_requester (
	input  logic                     clock,
	input  logic                     rstn,
	input  logic [63:0]              base_address,
	input  logic [31:0]              afu_config,
	input  edge_fetch_pkg::edge_job_t edge_job,
	input  logic                     edge_job_valid,
	output logic                     edge_job_ready,
	output edge_fetch_pkg::read_cmd_t read_cmd,
	output logic                     read_cmd_valid,
	input  logic                     read_cmd_ready,
	input  logic                     delivered
);

	import edge_fetch_pkg::*;

	edge_job_t                   job_head;
	logic                        job_empty;
	logic                        job_almost_full;
	logic                        cmd_almost_full;
	logic                        cmd_empty;
	logic                        form;
	logic [63:0]                 job_address;
	read_cmd_t                   cmd_next;
	read_cmd_t                   cmd_q;
	logic                        cmd_q_valid;
	logic [OUTSTANDING_BITS-1:0] outstanding;

	////////////////////////////////////////
	// job buffer
	////////////////////////////////////////
	sync_fifo #(
		.WIDTH($bits(edge_job_t)),
		.DEPTH(JOB_FIFO_DEPTH)
	) job_fifo_i (
		.clock      (clock),
		.rstn       (rstn),
		.push       (edge_job_valid && edge_job_ready),
		.data_in    (edge_job),
		.pop        (form),
		.data_out   (job_head),
		.full       (),
		.almost_full(job_almost_full),
		.empty      (job_empty)
	);

	// registered, one late push still fits
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			edge_job_ready <= 1'b0;
		end else begin
			edge_job_ready <= !job_almost_full;
		end
	end

	////////////////////////////////////////
	// command forming
	////////////////////////////////////////
	assign form        = !job_empty && (outstanding < MAX_OUTSTANDING) && !cmd_almost_full;
	assign job_address = base_address + {30'd0, job_head.dest, 2'b00};

	always_comb begin
		cmd_next.code       = afu_config[SHARED_READ_BIT] ? READ_CL_S : READ_CL_NA;
		cmd_next.address    = job_address;
		cmd_next.size       = 4'd4;
		cmd_next.tag.dest   = job_head.dest;
		cmd_next.tag.offset = job_address[5:2];
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			cmd_q_valid <= 1'b0;
		end else begin
			cmd_q_valid <= form;
		end
	end

	always_ff @(posedge clock) begin
		if (form) begin
			cmd_q <= cmd_next;
		end
	end

	// reads in flight, formed but not yet delivered
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			outstanding <= '0;
		end else begin
			case ({form, delivered})
				2'b10:   outstanding <= outstanding + 1'b1;
				2'b01:   outstanding <= outstanding - 1'b1;
				default: outstanding <= outstanding;
			endcase
		end
	end

	////////////////////////////////////////
	// command buffer
	////////////////////////////////////////
	sync_fifo #(
		.WIDTH($bits(read_cmd_t)),
		.DEPTH(JOB_FIFO_DEPTH)
	) cmd_fifo_i (
		.clock      (clock),
		.rstn       (rstn),
		.push       (cmd_q_valid),
		.data_in    (cmd_q),
		.pop        (read_cmd_valid && read_cmd_ready),
		.data_out   (read_cmd),
		.full       (),
		.almost_full(cmd_almost_full),
		.empty      (cmd_empty)
	);

	assign read_cmd_valid = !cmd_empty;

endmodule

//--- source/half_line_capture.sv
/* Captures one memory response lane and restores the byte order of each word.
   The half line waits in a queue until the extractor takes it. */

module half_line_capture (
	input  logic                      clock,
	input  logic                      rstn,
	input  edge_fetch_pkg::half_beat_t beat,
	input  logic                      beat_valid,
	output edge_fetch_pkg::half_beat_t half,
	output logic                      half_valid,
	input  logic                      take
);

	import edge_fetch_pkg::*;

	half_beat_t swapped;
	logic       empty;

	// byte-reverse every word, tag passes through
	always_comb begin
		swapped = beat;
		for (int w = 0; w < HALF_WORDS; w++) begin
			for (int b = 0; b < WORD_BITS / 8; b++) begin
				swapped.data[w*WORD_BITS + b*8 +: 8] =
					beat.data[w*WORD_BITS + (WORD_BITS/8 - 1 - b)*8 +: 8];
			end
		end
	end

	// credits keep this from overflowing
	sync_fifo #(
		.WIDTH($bits(half_beat_t)),
		.DEPTH(MAX_OUTSTANDING)
	) lane_fifo_i (
		.clock      (clock),
		.rstn       (rstn),
		.push       (beat_valid),
		.data_in    (swapped),
		.pop        (take),
		.data_out   (half),
		.full       (),
		.almost_full(),
		.empty      (empty)
	);

	assign half_valid = !empty;

endmodule

//--- source/line_word_extractor.sv
/* Joins the two half lines of a response, picks the requested word by offset
   and queues it with its dest as edge data. */

module line_word_extractor (
	input  logic                      clock,
	input  logic                      rstn,
	input  edge_fetch_pkg::half_beat_t half_lo,
	input  edge_fetch_pkg::half_beat_t half_hi,
	input  logic                      lo_valid,
	input  logic                      hi_valid,
	output logic                      take,
	output edge_fetch_pkg::edge_data_t edge_data,
	output logic                      edge_data_valid,
	input  logic                      edge_data_ready,
	output logic                      delivered
);

	import edge_fetch_pkg::*;

	cache_line_u line_q;
	read_tag_t   tag_q;
	logic        line_valid;
	edge_data_t  word_out;
	logic        out_empty;

	////////////////////////////////////////
	// line join
	////////////////////////////////////////
	// both lanes in command order, so heads belong together
	assign take = lo_valid && hi_valid;

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			line_valid <= 1'b0;
		end else begin
			line_valid <= take;
		end
	end

	always_ff @(posedge clock) begin
		if (take) begin
			line_q.halves[0] <= half_lo.data;
			line_q.halves[1] <= half_hi.data;
			tag_q            <= half_lo.tag;
		end
	end

	////////////////////////////////////////
	// word select
	////////////////////////////////////////
	always_comb begin
		word_out.dest = tag_q.dest;
		word_out.data = line_q.words[tag_q.offset];
	end

	// never overflows, outstanding reads bounded by depth
	sync_fifo #(
		.WIDTH($bits(edge_data_t)),
		.DEPTH(MAX_OUTSTANDING)
	) out_fifo_i (
		.clock      (clock),
		.rstn       (rstn),
		.push       (line_valid),
		.data_in    (word_out),
		.pop        (delivered),
		.data_out   (edge_data),
		.full       (),
		.almost_full(),
		.empty      (out_empty)
	);

	assign edge_data_valid = !out_empty;

	// one credit back per transfer
	assign delivered = edge_data_valid && edge_data_ready;

endmodule

//--- source/sync_fifo.sv
/* Synchronous first-word-fall-through FIFO.
   data_out shows the head entry whenever empty is low. */

module sync_fifo #(
	parameter int WIDTH = 32,
	parameter int DEPTH = 8
) (
	input  logic             clock,
	input  logic             rstn,
	input  logic             push,
	input  logic [WIDTH-1:0] data_in,
	input  logic             pop,
	output logic [WIDTH-1:0] data_out,
	output logic             full,
	output logic             almost_full,
	output logic             empty
);

	logic [WIDTH-1:0]           mem [DEPTH];
	logic [$clog2(DEPTH)-1:0]   wr_ptr;
	logic [$clog2(DEPTH)-1:0]   rd_ptr;
	logic [$clog2(DEPTH+1)-1:0] count;
	logic                       do_push;
	logic                       do_pop;

	assign do_pop  = pop && !empty;
	// a full buffer still takes a word when the head leaves
	assign do_push = push && (!full || do_pop);

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_push) begin
				wr_ptr <= (wr_ptr == DEPTH - 1) ? '0 : wr_ptr + 1'b1;
			end
			if (do_pop) begin
				rd_ptr <= (rd_ptr == DEPTH - 1) ? '0 : rd_ptr + 1'b1;
			end
			if (do_push && !do_pop) begin
				count <= count + 1'b1;
			end else if (do_pop && !do_push) begin
				count <= count - 1'b1;
			end
		end
	end

	// storage
	always_ff @(posedge clock) begin
		if (do_push) begin
			mem[wr_ptr] <= data_in;
		end
	end

	assign data_out    = mem[rd_ptr];
	assign empty       = (count == 0);
	assign full        = (count == DEPTH);
	assign almost_full = (count >= DEPTH - 1);

endmodule

//--- sources.f
source/edge_fetch_pkg.sv
source/sync_fifo.sv
source/edge_read_requester.sv
source/half_line_capture.sv
source/line_word_extractor.sv
source/edge_data_fetch.sv
tests/edge_fetch_checker.sv
tests/edge_fetch_tb.sv

//--- tests/edge_fetch_checker.sv
/* Protocol assertions for the edge data fetch unit, bound to its top level. */

module edge_fetch_checker (
	input logic                      clock,
	input logic                      rstn,
	input edge_fetch_pkg::read_cmd_t  read_cmd,
	input logic                      read_cmd_valid,
	input logic                      read_cmd_ready,
	input edge_fetch_pkg::edge_data_t edge_data,
	input logic                      edge_data_valid,
	input logic                      edge_data_ready,
	input logic [3:0]                outstanding,
	input logic                      take,
	input edge_fetch_pkg::read_tag_t  lo_tag,
	input edge_fetch_pkg::read_tag_t  hi_tag
);

	timeunit 1ns;
	timeprecision 1ps;

	import edge_fetch_pkg::*;

	// held commands must not change
	cmd_stable_a: assert property (@(posedge clock) disable iff (!rstn)
		read_cmd_valid && !read_cmd_ready |=> read_cmd_valid && $stable(read_cmd))
		else $error("read command changed while waiting for ready");

	data_stable_a: assert property (@(posedge clock) disable iff (!rstn)
		edge_data_valid && !edge_data_ready |=> edge_data_valid && $stable(edge_data))
		else $error("edge data changed while waiting for ready");

	credit_limit_a: assert property (@(posedge clock) disable iff (!rstn)
		outstanding <= MAX_OUTSTANDING)
		else $error("outstanding reads above the credit limit");

	// both heads belong to the same read
	pair_tag_a: assert property (@(posedge clock) disable iff (!rstn)
		take |-> lo_tag == hi_tag)
		else $error("half line tags differ at take");

endmodule

bind edge_data_fetch edge_fetch_checker checker_i (
	.clock          (clock),
	.rstn           (rstn),
	.read_cmd       (read_cmd),
	.read_cmd_valid (read_cmd_valid),
	.read_cmd_ready (read_cmd_ready),
	.edge_data      (edge_data),
	.edge_data_valid(edge_data_valid),
	.edge_data_ready(edge_data_ready),
	.outstanding    (requester_i.outstanding),
	.take           (take),
	.lo_tag         (lane0_half.tag),
	.hi_tag         (lane1_half.tag)
);

//--- tests/edge_fetch_tb.sv
/* Testbench of the edge data fetch unit. Random edge jobs, a memory responder
   with skewed lanes, and a scoreboard on read commands and edge data. */

module edge_fetch_tb;

	timeunit 1ns;
	timeprecision 1ps;

	import edge_fetch_pkg::*;

	localparam int TOTAL_JOBS = 120;

	logic        clock;
	logic        rstn;
	logic [63:0] base_address;
	logic [31:0] afu_config;
	edge_job_t   edge_job;
	logic        edge_job_valid;
	logic        edge_job_ready;
	read_cmd_t   read_cmd;
	logic        read_cmd_valid;
	logic        read_cmd_ready;
	half_beat_t  lane0_beat;
	logic        lane0_beat_valid;
	half_beat_t  lane1_beat;
	logic        lane1_beat_valid;
	edge_data_t  edge_data;
	logic        edge_data_valid;
	logic        edge_data_ready;

	// scoreboard state
	logic [31:0] cmd_dest_q [$];
	logic [31:0] exp_dest_q [$];
	logic [31:0] exp_data_q [$];
	half_beat_t  lane0_q [$];
	half_beat_t  lane1_q [$];
	int          lane0_due [$];
	int          lane1_due [$];
	int          cycle_count;
	int          job_count;
	int          cmd_count;
	int          out_count;
	int          error_count;
	logic        cmd_hold;
	logic        out_hold;
	logic        job_ready_dropped;
	logic        shared_phase;

	edge_data_fetch dut_i (.*);

	initial begin
		clock = 1'b0;
		forever #20 clock = ~clock;
	end

	////////////////////////////////////////
	// memory model
	////////////////////////////////////////
	function automatic logic [31:0] stored_word(input logic [63:0] a);
		logic [63:0] p;
		p = a * 64'h9E3779B1;
		return p[31:0] + a[31:0];
	endfunction

	function automatic logic [31:0] byte_reverse(input logic [31:0] w);
		return {w[7:0], w[15:8], w[23:16], w[31:24]};
	endfunction

	// property word of a vertex, four bytes per vertex
	function automatic logic [63:0] vertex_address(input logic [31:0] dest);
		return base_address + 64'(dest) * 64'd4;
	endfunction

	task automatic accept_command();
		logic [31:0] dest;
		logic [63:0] exp_addr;
		logic [63:0] line_base;
		cmd_code_e   exp_code;
		half_beat_t  b0;
		half_beat_t  b1;
		int          due;
		dest = cmd_dest_q.pop_front();
		exp_addr = vertex_address(dest);
		exp_code = shared_phase ? READ_CL_S : READ_CL_NA;
		assert (read_cmd.address == exp_addr) else begin
			$display("FAIL %0t read_cmd.address expected %h got %h", $time, exp_addr,
				read_cmd.address);
			error_count++;
		end
		assert (read_cmd.size == 4'd4) else begin
			$display("FAIL %0t read_cmd.size expected 4 got %0d", $time, read_cmd.size);
			error_count++;
		end
		assert (read_cmd.code == exp_code) else begin
			$display("FAIL %0t read_cmd.code expected %h got %h", $time, exp_code,
				read_cmd.code);
			error_count++;
		end
		assert (read_cmd.tag.dest == dest && read_cmd.tag.offset == exp_addr[5:2]) else begin
			$display("FAIL %0t read_cmd.tag expected %h/%h got %h/%h", $time, dest,
				exp_addr[5:2], read_cmd.tag.dest, read_cmd.tag.offset);
			error_count++;
		end
		// memory answers with the line of the command address
		line_base = {read_cmd.address[63:6], 6'd0};
		for (int i = 0; i < HALF_WORDS; i++) begin
			b0.data[i*32 +: 32] = byte_reverse(stored_word(line_base + 64'(4 * i)));
			b1.data[i*32 +: 32] = byte_reverse(stored_word(line_base + 64'(32 + 4 * i)));
		end
		b0.tag = read_cmd.tag;
		b1.tag = read_cmd.tag;
		due = cycle_count + 1 + $urandom_range(5);
		if (lane0_due.size() > 0 && lane0_due[$] > due) due = lane0_due[$];
		lane0_q.push_back(b0);
		lane0_due.push_back(due);
		due = cycle_count + 1 + $urandom_range(5);
		if (lane1_due.size() > 0 && lane1_due[$] > due) due = lane1_due[$];
		lane1_q.push_back(b1);
		lane1_due.push_back(due);
	endtask

	task automatic check_output();
		logic [31:0] exp_dest;
		logic [31:0] exp_data;
		if (exp_dest_q.size() == 0) begin
			$display("Edge data came out with no job waiting for it");
			error_count++;
			return;
		end
		exp_dest = exp_dest_q.pop_front();
		exp_data = exp_data_q.pop_front();
		assert (edge_data.dest == exp_dest) else begin
			$display("FAIL %0t edge_data.dest expected %h got %h", $time, exp_dest,
				edge_data.dest);
			error_count++;
		end
		assert (edge_data.data == exp_data) else begin
			$display("FAIL %0t edge_data.data expected %h got %h", $time, exp_data,
				edge_data.data);
			error_count++;
		end
	endtask

	// monitors, all sampled at the rising edge
	always @(posedge clock) begin
		if (rstn) begin
			cycle_count++;
			if (edge_job_valid && edge_job_ready) begin
				job_count++;
				cmd_dest_q.push_back(edge_job.dest);
				exp_dest_q.push_back(edge_job.dest);
				exp_data_q.push_back(stored_word(vertex_address(edge_job.dest)));
			end
			if (edge_data_valid && edge_data_ready) begin
				out_count++;
				check_output();
			end
			if (read_cmd_valid && read_cmd_ready) begin
				cmd_count++;
				accept_command();
				assert (cmd_count - out_count <= MAX_OUTSTANDING) else begin
					$display("FAIL %0t reads in flight expected <= %0d got %0d", $time,
						MAX_OUTSTANDING, cmd_count - out_count);
					error_count++;
				end
			end
			if (cmd_hold && !edge_job_ready) job_ready_dropped = 1'b1;
		end
	end

	// readies and lane beats change on the falling edge
	always @(negedge clock) begin
		read_cmd_ready  = !cmd_hold && ($urandom_range(3) != 0);
		edge_data_ready = !out_hold && ($urandom_range(3) != 0);
		lane0_beat_valid = 1'b0;
		lane1_beat_valid = 1'b0;
		if (lane0_q.size() > 0 && lane0_due[0] <= cycle_count) begin
			lane0_beat = lane0_q.pop_front();
			void'(lane0_due.pop_front());
			lane0_beat_valid = 1'b1;
		end
		if (lane1_q.size() > 0 && lane1_due[0] <= cycle_count) begin
			lane1_beat = lane1_q.pop_front();
			void'(lane1_due.pop_front());
			lane1_beat_valid = 1'b1;
		end
	end

	////////////////////////////////////////
	// stimulus
	////////////////////////////////////////
	task automatic send_job();
		@(negedge clock);
		edge_job_valid = 1'b1;
		edge_job.src   = $urandom();
		edge_job.dest  = $urandom();
		do @(posedge clock); while (!edge_job_ready);
		@(negedge clock);
		edge_job_valid = 1'b0;
		repeat ($urandom_range(2)) @(negedge clock);
	endtask

	task automatic send_jobs(input int n);
		for (int i = 0; i < n; i++) send_job();
	endtask

	task automatic drain();
		do @(negedge clock); while (out_count != job_count);
	endtask

	initial begin
		repeat (TOTAL_JOBS * 60 + 2000) @(posedge clock);
		$display("Watchdog timeout: the run did not finish in time, %0d errors", error_count);
		$display("Test failures found");
		$finish;
	end

	initial begin
		void'($urandom(72));
		rstn = 1'b0;
		base_address = 64'h0000_0040_0000_1000;
		afu_config = 32'h8000_0000;
		shared_phase = 1'b1;
		edge_job = '0;
		edge_job_valid = 1'b0;
		read_cmd_ready = 1'b0;
		edge_data_ready = 1'b0;
		lane0_beat = '0;
		lane0_beat_valid = 1'b0;
		lane1_beat = '0;
		lane1_beat_valid = 1'b0;
		cycle_count = 0;
		job_count = 0;
		cmd_count = 0;
		out_count = 0;
		error_count = 0;
		cmd_hold = 1'b0;
		out_hold = 1'b0;
		job_ready_dropped = 1'b0;

		repeat (5) @(negedge clock);
		assert (!edge_job_ready && !read_cmd_valid && !edge_data_valid) else begin
			$display("Outputs were not idle during reset");
			error_count++;
		end
		repeat (5) @(negedge clock);
		rstn = 1'b1;
		repeat (3) @(negedge clock);
		assert (edge_job_ready && !read_cmd_valid && !edge_data_valid) else begin
			$display("Outputs not idle with job ready high after reset");
			error_count++;
		end

		// shared reads, then non-allocating reads
		send_jobs(40);
		drain();
		@(negedge clock);
		afu_config = 32'h0000_0000;
		shared_phase = 1'b0;
		send_jobs(40);
		drain();

		// output stall against the credit limit
		out_hold = 1'b1;
		fork
			send_jobs(24);
			begin
				repeat (300) @(negedge clock);
				assert (cmd_count - out_count == MAX_OUTSTANDING) else begin
					$display("FAIL %0t reads in flight expected %0d got %0d", $time,
						MAX_OUTSTANDING, cmd_count - out_count);
					error_count++;
				end
				out_hold = 1'b0;
			end
		join
		drain();

		// command stall reaches the job input
		cmd_hold = 1'b1;
		fork
			send_jobs(16);
			begin
				repeat (120) @(negedge clock);
				assert (job_ready_dropped) else begin
					$display("Job ready never dropped while commands were held");
					error_count++;
				end
				cmd_hold = 1'b0;
			end
		join
		drain();
		repeat (20) @(negedge clock);

		assert (cmd_count == job_count && out_count == job_count) else begin
			$display("Counts differ: %0d jobs, %0d commands, %0d outputs", job_count,
				cmd_count, out_count);
			error_count++;
		end
		$display("Done: %0d jobs, %0d errors", job_count, error_count);
		if (error_count == 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

endmodule
